// File: gat.f
gat_pkg.sv
gat_bram.sv
gat_spmm.sv
gat_top.sv
gat_top_wrapper.sv
tb_gat_top_wrapper.sv

// File: gat_bram.sv
`timescale 1ns/1ps

module gat_bram #(
  parameter int    DEPTH  = 16,
  parameter type   T      = logic [7:0],
  localparam int   ADDR_W = $clog2(DEPTH)
) (
  input  logic              clk,

  // Write port
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  T                  wr_data,

  // Read port, data one cycle after the address
  input  logic [ADDR_W-1:0] rd_addr,
  output T                  rd_data
);

  T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, always enabled
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // Host and engine writes must stay inside the array
  a_wr_in_range: assert property (
    @(posedge clk) wr_en |-> (wr_addr < DEPTH)
  ) else $error("gat_bram write address %0d out of range (depth %0d)", wr_addr, DEPTH);

endmodule

// File: gat_pkg.sv
package gat_pkg;

  // ====================
  // Bus constants
  // ====================

  // Host data word width
  localparam int TOP_WIDTH  = 32;

  // Byte address bits below the word index
  localparam int BYTE_LSB   = 2;

  // ====================
  // Element types
  // ====================

  // Feature value and weight width
  localparam int DATA_WIDTH = 8;

  typedef logic signed [DATA_WIDTH-1:0] data_t;

  // Controller states, visible to the host on gat_debug_3
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    FETCH_INFO = 3'd1,
    RUN_ROW    = 3'd2,
    WAIT_ROW   = 3'd3,
    DONE       = 3'd4
  } gat_state_e;

endpackage

// File: gat_spmm.sv
`timescale 1ns/1ps

module gat_spmm
  import gat_pkg::*;
#(
  parameter int  TOTAL_NODES       = 8,
  parameter int  NUM_FEATURE_IN    = 16,
  parameter int  NUM_FEATURE_OUT   = 4,
  parameter int  H_NUM_SPARSE_DATA = 48,
  parameter int  NEW_FEATURE_WIDTH = 32,

  localparam int COL_W       = $clog2(NUM_FEATURE_IN),
  localparam int H_DATA_W    = DATA_WIDTH + COL_W,
  localparam int H_ADDR_W    = $clog2(H_NUM_SPARSE_DATA),
  localparam int ROW_LEN_W   = $clog2(NUM_FEATURE_IN + 1),
  localparam int NODE_W      = $clog2(TOTAL_NODES),
  localparam int W_ADDR_W    = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT),
  localparam int FEAT_ADDR_W = $clog2(TOTAL_NODES * NUM_FEATURE_OUT),
  localparam int OUT_W       = (NUM_FEATURE_OUT > 1) ? $clog2(NUM_FEATURE_OUT) : 1
) (
  input  logic                                clk,
  input  logic                                arst_n,

  // Row command from the controller
  input  logic                                row_start,
  input  logic        [H_ADDR_W-1:0]          row_base,
  input  logic        [ROW_LEN_W-1:0]         row_len,
  input  logic        [NODE_W-1:0]            node,

  // Sparse H memory
  output logic        [H_ADDR_W-1:0]          h_rd_addr,
  input  logic        [H_DATA_W-1:0]          h_rd_data,

  // Weight memory
  output logic        [W_ADDR_W-1:0]          w_rd_addr,
  input  data_t                               w_rd_data,

  // Feature memory write port
  output logic                                feat_we,
  output logic        [FEAT_ADDR_W-1:0]       feat_waddr,
  output logic signed [NEW_FEATURE_WIDTH-1:0] feat_wdata,

  output logic                                row_done,
  output logic                                busy
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HREAD,
    S_WREAD,
    S_FLUSH,
    S_WRITE
  } eng_state_e;

  eng_state_e                        state;
  logic        [H_ADDR_W-1:0]        ptr;
  logic        [ROW_LEN_W-1:0]       remain;
  logic        [OUT_W-1:0]           out_idx;
  logic        [NODE_W-1:0]          node_r;

  // MAC stage, one cycle behind the weight read
  logic                              mac_en;
  logic        [OUT_W-1:0]           mac_idx;
  data_t                             mac_val;
  logic signed [2*DATA_WIDTH-1:0]    prod;

  logic signed [NEW_FEATURE_WIDTH-1:0] acc [NUM_FEATURE_OUT];

  data_t                             h_val;
  logic        [COL_W-1:0]           h_col;
  logic                              last_out;

  assign h_val    = data_t'(h_rd_data[DATA_WIDTH-1:0]);
  assign h_col    = h_rd_data[DATA_WIDTH +: COL_W];
  assign last_out = (out_idx == OUT_W'(NUM_FEATURE_OUT - 1));
  assign prod     = mac_val * w_rd_data;

  // ====================
  // Sequencer
  // ====================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= S_IDLE;
      ptr      <= '0;
      remain   <= '0;
      out_idx  <= '0;
      mac_en   <= 1'b0;
      row_done <= 1'b0;
    end else begin
      mac_en   <= (state == S_WREAD);
      row_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (row_start) begin
            ptr     <= row_base;
            remain  <= row_len;
            out_idx <= '0;
            // Empty row goes straight to writing zeros
            state   <= (row_len == '0) ? S_FLUSH : S_HREAD;
          end
        end
        // H word settles on the read port
        S_HREAD: state <= S_WREAD;
        S_WREAD: begin
          if (last_out) begin
            out_idx <= '0;
            ptr     <= ptr + 1'b1;
            remain  <= remain - 1'b1;
            state   <= (remain == ROW_LEN_W'(1)) ? S_FLUSH : S_HREAD;
          end else begin
            out_idx <= out_idx + 1'b1;
          end
        end
        // Let the trailing MAC land
        S_FLUSH: state <= S_WRITE;
        S_WRITE: begin
          if (last_out) begin
            out_idx  <= '0;
            row_done <= 1'b1;
            state    <= S_IDLE;
          end else begin
            out_idx <= out_idx + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ====================
  // Datapath
  // ====================

  always_ff @(posedge clk) begin
    if (state == S_WREAD) begin
      mac_idx <= out_idx;
      mac_val <= h_val;
    end
    if ((state == S_IDLE) && row_start) begin
      node_r <= node;
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        acc[i] <= '0;
      end
    end else if (mac_en) begin
      acc[mac_idx] <= acc[mac_idx] + prod;
    end
  end

  // H address holds until the last weight read of a nonzero
  assign h_rd_addr  = ptr;
  assign w_rd_addr  = W_ADDR_W'(h_col) * W_ADDR_W'(NUM_FEATURE_OUT) + W_ADDR_W'(out_idx);

  assign feat_we    = (state == S_WRITE);
  assign feat_waddr = FEAT_ADDR_W'(node_r) * FEAT_ADDR_W'(NUM_FEATURE_OUT)
                    + FEAT_ADDR_W'(out_idx);
  assign feat_wdata = acc[out_idx];

  assign busy       = (state != S_IDLE);

  // Controller must wait for the previous node
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!arst_n) row_start |-> !busy
  ) else $error("row_start issued while the engine is busy");

endmodule

// File: gat_top.sv
`timescale 1ns/1ps

module gat_top
  import gat_pkg::*;
#(
  parameter int  TOTAL_NODES       = 8,
  parameter int  NUM_FEATURE_IN    = 16,
  parameter int  NUM_FEATURE_OUT   = 4,
  parameter int  H_NUM_SPARSE_DATA = 48,
  parameter int  NEW_FEATURE_WIDTH = 32,

  localparam int COL_W       = $clog2(NUM_FEATURE_IN),
  localparam int H_DATA_W    = DATA_WIDTH + COL_W,
  localparam int H_ADDR_W    = $clog2(H_NUM_SPARSE_DATA),
  localparam int ROW_LEN_W   = $clog2(NUM_FEATURE_IN + 1),
  localparam int NODE_W      = $clog2(TOTAL_NODES),
  localparam int NODE_CNT_W  = $clog2(TOTAL_NODES + 1),
  localparam int NNZ_W       = $clog2(H_NUM_SPARSE_DATA + 1),
  localparam int W_ADDR_W    = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT),
  localparam int FEAT_ADDR_W = $clog2(TOTAL_NODES * NUM_FEATURE_OUT),
  localparam int STATE_W     = $bits(gat_state_e)
) (
  input  logic                                clk,
  input  logic                                arst_n,

  // Register bank
  output logic                                gat_ready,
  output logic        [NODE_CNT_W-1:0]        gat_debug_1,
  output logic        [NNZ_W-1:0]             gat_debug_2,
  output logic        [STATE_W-1:0]           gat_debug_3,
  input  logic                                h_data_bram_load_done,
  input  logic                                h_node_info_bram_load_done,
  input  logic                                wgt_bram_load_done,

  // Host write ports, word indexed
  input  logic        [H_DATA_W-1:0]          h_data_bram_din,
  input  logic                                h_data_bram_ena,
  input  logic                                h_data_bram_wea,
  input  logic        [H_ADDR_W-1:0]          h_data_bram_addra,

  input  logic        [ROW_LEN_W-1:0]         h_node_info_bram_din,
  input  logic                                h_node_info_bram_ena,
  input  logic                                h_node_info_bram_wea,
  input  logic        [NODE_W-1:0]            h_node_info_bram_addra,

  input  logic        [DATA_WIDTH-1:0]        wgt_bram_din,
  input  logic                                wgt_bram_ena,
  input  logic                                wgt_bram_wea,
  input  logic        [W_ADDR_W-1:0]          wgt_bram_addra,

  // Host result read
  input  logic        [FEAT_ADDR_W-1:0]       feat_bram_addrb,
  output logic signed [NEW_FEATURE_WIDTH-1:0] feat_bram_dout
);

  gat_state_e                         state;
  logic        [NODE_CNT_W-1:0]       done_cnt;
  logic        [NNZ_W-1:0]            nnz_cnt;
  logic        [ROW_LEN_W-1:0]        cur_len;
  logic                               all_loaded;

  logic        [ROW_LEN_W-1:0]        ni_rd_data;

  // Engine side
  logic                               row_start;
  logic                               row_done;
  logic                               eng_busy;
  logic        [H_ADDR_W-1:0]         h_rd_addr;
  logic        [H_DATA_W-1:0]         h_rd_data;
  logic        [W_ADDR_W-1:0]         w_rd_addr;
  data_t                              w_rd_data;
  logic                               feat_we;
  logic        [FEAT_ADDR_W-1:0]      feat_waddr;
  logic signed [NEW_FEATURE_WIDTH-1:0] feat_wdata;

  assign all_loaded = h_data_bram_load_done & h_node_info_bram_load_done & wgt_bram_load_done;

  // ====================
  // Controller FSM
  // ====================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      done_cnt  <= '0;
      nnz_cnt   <= '0;
      cur_len   <= '0;
      gat_ready <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (all_loaded && !gat_ready) begin
            state <= FETCH_INFO;
          end
        end
        // Row length read in flight, engine must be free
        FETCH_INFO: begin
          if (!eng_busy) begin
            state <= RUN_ROW;
          end
        end
        RUN_ROW: begin
          cur_len <= ni_rd_data;
          state   <= WAIT_ROW;
        end
        WAIT_ROW: begin
          if (row_done) begin
            done_cnt <= done_cnt + 1'b1;
            nnz_cnt  <= nnz_cnt + NNZ_W'(cur_len);
            if (done_cnt == NODE_CNT_W'(TOTAL_NODES - 1)) begin
              gat_ready <= 1'b1;
              state     <= DONE;
            end else begin
              state <= FETCH_INFO;
            end
          end
        end
        // One pass per reset
        DONE: state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  assign row_start   = (state == RUN_ROW);

  assign gat_debug_1 = done_cnt;
  assign gat_debug_2 = nnz_cnt;
  assign gat_debug_3 = state;

  // ====================
  // Memories
  // ====================

  gat_bram #(
    .DEPTH   (H_NUM_SPARSE_DATA),
    .T       (logic [H_DATA_W-1:0])
  ) u_h_data_bram (
    .clk     (clk),
    .wr_en   (h_data_bram_ena & h_data_bram_wea),
    .wr_addr (h_data_bram_addra),
    .wr_data (h_data_bram_din),
    .rd_addr (h_rd_addr),
    .rd_data (h_rd_data)
  );

  // Read port follows the node being processed
  gat_bram #(
    .DEPTH   (TOTAL_NODES),
    .T       (logic [ROW_LEN_W-1:0])
  ) u_node_info_bram (
    .clk     (clk),
    .wr_en   (h_node_info_bram_ena & h_node_info_bram_wea),
    .wr_addr (h_node_info_bram_addra),
    .wr_data (h_node_info_bram_din),
    .rd_addr (done_cnt[NODE_W-1:0]),
    .rd_data (ni_rd_data)
  );

  gat_bram #(
    .DEPTH   (NUM_FEATURE_IN * NUM_FEATURE_OUT),
    .T       (data_t)
  ) u_wgt_bram (
    .clk     (clk),
    .wr_en   (wgt_bram_ena & wgt_bram_wea),
    .wr_addr (wgt_bram_addra),
    .wr_data (wgt_bram_din),
    .rd_addr (w_rd_addr),
    .rd_data (w_rd_data)
  );

  gat_bram #(
    .DEPTH   (TOTAL_NODES * NUM_FEATURE_OUT),
    .T       (logic signed [NEW_FEATURE_WIDTH-1:0])
  ) u_feat_bram (
    .clk     (clk),
    .wr_en   (feat_we),
    .wr_addr (feat_waddr),
    .wr_data (feat_wdata),
    .rd_addr (feat_bram_addrb),
    .rd_data (feat_bram_dout)
  );

  // ====================
  // SpMM engine
  // ====================

  gat_spmm #(
    .TOTAL_NODES       (TOTAL_NODES),
    .NUM_FEATURE_IN    (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT   (NUM_FEATURE_OUT),
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA),
    .NEW_FEATURE_WIDTH (NEW_FEATURE_WIDTH)
  ) u_spmm (
    .clk        (clk),
    .arst_n     (arst_n),
    .row_start  (row_start),
    .row_base   (nnz_cnt[H_ADDR_W-1:0]),
    .row_len    (ni_rd_data),
    .node       (done_cnt[NODE_W-1:0]),
    .h_rd_addr  (h_rd_addr),
    .h_rd_data  (h_rd_data),
    .w_rd_addr  (w_rd_addr),
    .w_rd_data  (w_rd_data),
    .feat_we    (feat_we),
    .feat_waddr (feat_waddr),
    .feat_wdata (feat_wdata),
    .row_done   (row_done),
    .busy       (eng_busy)
  );

  // Completion flag is sticky until the next reset
  a_ready_sticky: assert property (
    @(posedge clk) disable iff (!arst_n) gat_ready |=> gat_ready
  ) else $error("gat_ready fell without reset");

endmodule

// File: gat_top_wrapper.sv
`timescale 1ns/1ps

module gat_top_wrapper
  import gat_pkg::*;
#(
  parameter int  TOTAL_NODES       = 8,
  parameter int  NUM_FEATURE_IN    = 16,
  parameter int  NUM_FEATURE_OUT   = 4,
  parameter int  H_NUM_SPARSE_DATA = 48,
  parameter int  NEW_FEATURE_WIDTH = 32,

  localparam int COL_W       = $clog2(NUM_FEATURE_IN),
  localparam int H_DATA_W    = DATA_WIDTH + COL_W,
  localparam int H_ADDR_W    = $clog2(H_NUM_SPARSE_DATA),
  localparam int ROW_LEN_W   = $clog2(NUM_FEATURE_IN + 1),
  localparam int NODE_W      = $clog2(TOTAL_NODES),
  localparam int NODE_CNT_W  = $clog2(TOTAL_NODES + 1),
  localparam int NNZ_W       = $clog2(H_NUM_SPARSE_DATA + 1),
  localparam int W_ADDR_W    = $clog2(NUM_FEATURE_IN * NUM_FEATURE_OUT),
  localparam int FEAT_ADDR_W = $clog2(TOTAL_NODES * NUM_FEATURE_OUT),
  localparam int STATE_W     = $bits(gat_state_e)
) (
  input  logic                                  clk,
  input  logic                                  arst_n,

  // ====================
  // Register bank
  // ====================
  output logic                                  gat_ready,
  output logic [TOP_WIDTH-1:0]                  gat_debug_1,
  output logic [TOP_WIDTH-1:0]                  gat_debug_2,
  output logic [TOP_WIDTH-1:0]                  gat_debug_3,
  input  logic                                  h_data_bram_load_done,
  input  logic                                  h_node_info_bram_load_done,
  input  logic                                  wgt_bram_load_done,

  // ====================
  // BRAM ports, byte addressed
  // ====================
  input  logic [TOP_WIDTH-1:0]                  h_data_bram_din,
  input  logic                                  h_data_bram_ena,
  input  logic                                  h_data_bram_wea,
  input  logic [H_ADDR_W+BYTE_LSB-1:0]          h_data_bram_addra,

  input  logic [TOP_WIDTH-1:0]                  h_node_info_bram_din,
  input  logic                                  h_node_info_bram_ena,
  input  logic                                  h_node_info_bram_wea,
  input  logic [NODE_W+BYTE_LSB-1:0]            h_node_info_bram_addra,

  input  logic [TOP_WIDTH-1:0]                  wgt_bram_din,
  input  logic                                  wgt_bram_ena,
  input  logic                                  wgt_bram_wea,
  input  logic [W_ADDR_W+BYTE_LSB-1:0]          wgt_bram_addra,

  input  logic [FEAT_ADDR_W+BYTE_LSB-1:0]       feat_bram_addrb,
  output logic signed [NEW_FEATURE_WIDTH-1:0]   feat_bram_dout
);

  logic [NODE_CNT_W-1:0] dbg_nodes;
  logic [NNZ_W-1:0]      dbg_nnz;
  logic [STATE_W-1:0]    dbg_state;

  // Debug words are zero extended to the bus width
  assign gat_debug_1 = TOP_WIDTH'(dbg_nodes);
  assign gat_debug_2 = TOP_WIDTH'(dbg_nnz);
  assign gat_debug_3 = TOP_WIDTH'(dbg_state);

  gat_top #(
    .TOTAL_NODES       (TOTAL_NODES),
    .NUM_FEATURE_IN    (NUM_FEATURE_IN),
    .NUM_FEATURE_OUT   (NUM_FEATURE_OUT),
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA),
    .NEW_FEATURE_WIDTH (NEW_FEATURE_WIDTH)
  ) u_gat_top (
    .clk                        (clk),
    .arst_n                     (arst_n),

    .gat_ready                  (gat_ready),
    .gat_debug_1                (dbg_nodes),
    .gat_debug_2                (dbg_nnz),
    .gat_debug_3                (dbg_state),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),

    // Payload slices and word indices
    .h_data_bram_din            (h_data_bram_din[H_DATA_W-1:0]),
    .h_data_bram_ena            (h_data_bram_ena),
    .h_data_bram_wea            (h_data_bram_wea),
    .h_data_bram_addra          (h_data_bram_addra[H_ADDR_W+BYTE_LSB-1:BYTE_LSB]),

    .h_node_info_bram_din       (h_node_info_bram_din[ROW_LEN_W-1:0]),
    .h_node_info_bram_ena       (h_node_info_bram_ena),
    .h_node_info_bram_wea       (h_node_info_bram_wea),
    .h_node_info_bram_addra     (h_node_info_bram_addra[NODE_W+BYTE_LSB-1:BYTE_LSB]),

    .wgt_bram_din               (wgt_bram_din[DATA_WIDTH-1:0]),
    .wgt_bram_ena               (wgt_bram_ena),
    .wgt_bram_wea               (wgt_bram_wea),
    .wgt_bram_addra             (wgt_bram_addra[W_ADDR_W+BYTE_LSB-1:BYTE_LSB]),

    .feat_bram_addrb            (feat_bram_addrb[FEAT_ADDR_W+BYTE_LSB-1:BYTE_LSB]),
    .feat_bram_dout             (feat_bram_dout)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the GAT testbench with Verilator, result taken from sim.log
set -o pipefail
rm -f sim.log
verilator --binary -f gat.f --top-module tb_gat_top_wrapper \
  && ./obj_dir/Vtb_gat_top_wrapper 2>&1 | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }
grep -q "SIMULATION FAILED" sim.log \
  && { echo "Testbench reported failure"; exit 1; } \
  || { echo "No failure found in sim.log"; exit 0; }

// File: tb_gat_top_wrapper.sv
`timescale 1ns/1ps

module tb_gat_top_wrapper
  import gat_pkg::*;
();

  localparam int NODES     = 8;
  localparam int F_IN      = 16;
  localparam int F_OUT     = 4;
  localparam int NNZ_DEPTH = 48;
  localparam int H_BA_W    = $clog2(NNZ_DEPTH) + BYTE_LSB;
  localparam int NI_BA_W   = $clog2(NODES) + BYTE_LSB;
  localparam int W_BA_W    = $clog2(F_IN * F_OUT) + BYTE_LSB;
  localparam int F_BA_W    = $clog2(NODES * F_OUT) + BYTE_LSB;
  localparam data_t DATA_MIN = 8'sh80;
  localparam data_t DATA_MAX = 8'sh7f;

  // Watchdog budget for two passes with margin
  localparam int NUM_RUNS    = 2;
  localparam int LOAD_WRITES = NNZ_DEPTH + NODES + F_IN * F_OUT;
  localparam int READS       = 2 * NODES * F_OUT;
  localparam int RUN_CYCLES  = LOAD_WRITES + NNZ_DEPTH * (F_OUT + 1) + NODES * (F_OUT + 3) + READS;
  localparam int WATCHDOG_NS = 2 * NUM_RUNS * RUN_CYCLES * 10 + 1000;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 gat_ready;
  logic [TOP_WIDTH-1:0] gat_debug_1;
  logic [TOP_WIDTH-1:0] gat_debug_2;
  logic [TOP_WIDTH-1:0] gat_debug_3;
  logic                 h_done;
  logic                 ni_done;
  logic                 w_done;
  logic [TOP_WIDTH-1:0] h_din;
  logic                 h_ena;
  logic                 h_wea;
  logic [H_BA_W-1:0]    h_addr;
  logic [TOP_WIDTH-1:0] ni_din;
  logic                 ni_ena;
  logic                 ni_wea;
  logic [NI_BA_W-1:0]   ni_addr;
  logic [TOP_WIDTH-1:0] w_din;
  logic                 w_ena;
  logic                 w_wea;
  logic [W_BA_W-1:0]    w_addr;
  logic [F_BA_W-1:0]    feat_addr;
  logic signed [31:0]   feat_dout;

  // ====================
  // Stimulus and expected tables
  // ====================
  int                 row_len_tab [NODES];
  data_t              val_tab     [NNZ_DEPTH];
  logic [3:0]         col_tab     [NNZ_DEPTH];
  data_t              wgt_tab     [F_IN * F_OUT];
  logic signed [31:0] exp_tab     [NODES * F_OUT];
  int                 nnz_total;
  int                 seed = 28;
  int                 error_count = 0;
  int                 check_count = 0;

  gat_top_wrapper uut (
    .clk                        (clk),
    .arst_n                     (arst_n),
    .gat_ready                  (gat_ready),
    .gat_debug_1                (gat_debug_1),
    .gat_debug_2                (gat_debug_2),
    .gat_debug_3                (gat_debug_3),
    .h_data_bram_load_done      (h_done),
    .h_node_info_bram_load_done (ni_done),
    .wgt_bram_load_done         (w_done),
    .h_data_bram_din            (h_din),
    .h_data_bram_ena            (h_ena),
    .h_data_bram_wea            (h_wea),
    .h_data_bram_addra          (h_addr),
    .h_node_info_bram_din       (ni_din),
    .h_node_info_bram_ena       (ni_ena),
    .h_node_info_bram_wea       (ni_wea),
    .h_node_info_bram_addra     (ni_addr),
    .wgt_bram_din               (w_din),
    .wgt_bram_ena               (w_ena),
    .wgt_bram_wea               (w_wea),
    .wgt_bram_addra             (w_addr),
    .feat_bram_addrb            (feat_addr),
    .feat_bram_dout             (feat_dout)
  );

  always #5 clk = ~clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      $display("Error at %0t ns: %s got %0d, expected %0d",
               $time, name, $signed(got), $signed(expected));
      error_count++;
    end
  endtask

  // Random rows, or the fixed edge rows when edge_case is set
  task automatic build_tables(input bit edge_case);
    int k;
    int base;
    int acc;
    k = 0;
    for (int i = 0; i < F_IN * F_OUT; i++) begin
      wgt_tab[i] = data_t'($random(seed));
    end
    for (int n = 0; n < NODES; n++) begin
      row_len_tab[n] = int'(($random(seed) & 32'h7fff_ffff) % 7);
    end
    if (edge_case) begin
      row_len_tab[0] = 0;
      row_len_tab[1] = 1;
      row_len_tab[2] = 3;
      row_len_tab[3] = F_IN;
      wgt_tab[0]                 = DATA_MIN;
      wgt_tab[1]                 = DATA_MAX;
      wgt_tab[(F_IN - 1) * F_OUT] = DATA_MIN;
    end
    for (int n = 0; n < NODES; n++) begin
      for (int j = 0; j < row_len_tab[n]; j++) begin
        val_tab[k] = data_t'($random(seed));
        col_tab[k] = 4'($random(seed));
        if (edge_case && n == 1) begin
          col_tab[k] = 4'(F_IN - 1);
        end
        if (edge_case && n == 2) begin
          val_tab[k] = DATA_MIN;
          col_tab[k] = 4'd0;
        end
        if (edge_case && n == 3) begin
          val_tab[k] = (j % 2 == 0) ? DATA_MIN : DATA_MAX;
          col_tab[k] = 4'(j);
        end
        k++;
      end
    end
    nnz_total = k;
    // Reference model of WH[n][o] as the sum of value * W[col][o]
    base = 0;
    for (int n = 0; n < NODES; n++) begin
      for (int o = 0; o < F_OUT; o++) begin
        acc = 0;
        for (int j = 0; j < row_len_tab[n]; j++) begin
          acc += int'(val_tab[base + j]) * int'(wgt_tab[int'(col_tab[base + j]) * F_OUT + o]);
        end
        exp_tab[n * F_OUT + o] = acc;
      end
      base += row_len_tab[n];
    end
  endtask

  task automatic apply_reset();
    arst_n  = 1'b0;
    h_done  = 1'b0;
    ni_done = 1'b0;
    w_done  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  // H words go to unaligned byte addresses
  task automatic load_memories();
    for (int k = 0; k < nnz_total; k++) begin
      @(posedge clk);
      #1;
      h_ena  = 1'b1;
      h_wea  = 1'b1;
      h_addr = H_BA_W'((k << BYTE_LSB) + (k % 4));
      h_din  = TOP_WIDTH'({col_tab[k], val_tab[k]});
    end
    for (int n = 0; n < NODES; n++) begin
      @(posedge clk);
      #1;
      h_ena   = 1'b0;
      h_wea   = 1'b0;
      ni_ena  = 1'b1;
      ni_wea  = 1'b1;
      ni_addr = NI_BA_W'(n << BYTE_LSB);
      ni_din  = TOP_WIDTH'(row_len_tab[n]);
    end
    for (int i = 0; i < F_IN * F_OUT; i++) begin
      @(posedge clk);
      #1;
      ni_ena = 1'b0;
      ni_wea = 1'b0;
      w_ena  = 1'b1;
      w_wea  = 1'b1;
      w_addr = W_BA_W'(i << BYTE_LSB);
      w_din  = TOP_WIDTH'(wgt_tab[i]);
    end
    @(posedge clk);
    #1;
    w_ena = 1'b0;
    w_wea = 1'b0;
  endtask

  // Aligned read, then the same word with nonzero low bits
  task automatic read_results();
    int idx;
    for (int n = 0; n < NODES; n++) begin
      for (int o = 0; o < F_OUT; o++) begin
        idx = n * F_OUT + o;
        feat_addr = F_BA_W'(idx << BYTE_LSB);
        @(posedge clk);
        #1;
        check($sformatf("feat_bram_dout[%0d][%0d]", n, o), feat_dout, exp_tab[idx]);
        feat_addr = F_BA_W'((idx << BYTE_LSB) + 1 + (idx % 3));
        @(posedge clk);
        #1;
        check($sformatf("feat_bram_dout[%0d][%0d] unaligned", n, o), feat_dout, exp_tab[idx]);
      end
    end
  endtask

  task automatic run_pass(input bit edge_case);
    build_tables(edge_case);
    apply_reset();
    check("gat_ready after reset", 32'(gat_ready), 32'd0);
    check("gat_debug_1 after reset", gat_debug_1, 32'd0);
    check("gat_debug_2 after reset", gat_debug_2, 32'd0);
    check("gat_debug_3 after reset", gat_debug_3, 32'd0);
    load_memories();
    // Pass must stay idle while the weight flag is low
    h_done  = 1'b1;
    ni_done = 1'b1;
    repeat (20) begin
      @(posedge clk);
      #1;
      check("gat_ready before last load_done", 32'(gat_ready), 32'd0);
      check("gat_debug_2 before last load_done", gat_debug_2, 32'd0);
      check("gat_debug_3 before last load_done", gat_debug_3, 32'(IDLE));
    end
    w_done = 1'b1;
    while (gat_ready !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    check("gat_debug_1 at ready", gat_debug_1, 32'(NODES));
    check("gat_debug_2 at ready", gat_debug_2, 32'(nnz_total));
    check("gat_debug_3 at ready", gat_debug_3, 32'(DONE));
    read_results();
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    arst_n    = 1'b0;
    h_done    = 1'b0;
    ni_done   = 1'b0;
    w_done    = 1'b0;
    h_din     = '0;
    h_ena     = 1'b0;
    h_wea     = 1'b0;
    h_addr    = '0;
    ni_din    = '0;
    ni_ena    = 1'b0;
    ni_wea    = 1'b0;
    ni_addr   = '0;
    w_din     = '0;
    w_ena     = 1'b0;
    w_wea     = 1'b0;
    w_addr    = '0;
    feat_addr = '0;
    run_pass(1'b0);
    run_pass(1'b1);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
